// File: Bender.yml
package:
  name: pipelined_multiplier_unit

sources:
  # packages first, then interface and RTL
  - files:
      - logic/BasicTypes.sv
      - logic/MicroOpTypes.sv
      - logic/MulStageIf.sv
      - logic/MulIssueControl.sv
      - logic/PipelinedMultiplier.sv
      - logic/MulResultStage.sv
      - logic/PipelinedMultiplierUnit.sv

  # testbench, top module MulUnitTb
  - target: test
    files:
      - dv/MulClockGen.sv
      - dv/MulUnitAssertions.sv
      - dv/MulUnitTb.sv

// File: dv/MulClockGen.sv
`timescale 1ns/1ps
`default_nettype none

// free running clock plus a synchronous reset pulse
module MulClockGen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // reset drops on a rising edge like any other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : MulClockGen

`default_nettype wire

// File: dv/MulUnitAssertions.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the top-level ports of the multiply unit
module MulUnitAssertions (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                stall,
    input wire logic                opValid,
    input wire logic                resultValid,
    input wire BasicTypes::DataPath result
);
    import BasicTypes::*;

    // number of failed protocol checks
    int protocolErrors = 0;

    // no result while in reset, nor on the first edge after it
    resetQuiet: assert property (@(posedge clk)
        (rst || $fell(rst)) |=> !resultValid)
    else begin
        $error("resultValid high during or right after reset");
        protocolErrors++;
    end

    // stall freezes the whole output register
    stallHold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(resultValid) && $stable(result))
    else begin
        $error("output changed on a stalled edge");
        protocolErrors++;
    end

    // accept edge is the first of depth+1 register edges,
    // so depth more non-stalled edges, then valid is visible
    latency: assert property (@(posedge clk) disable iff (rst)
        (opValid && !stall) |->
            ##1 (!stall) [-> MUL_PIPELINE_DEPTH] ##1 resultValid)
    else begin
        $error("accepted op did not come out after the pipeline latency");
        protocolErrors++;
    end

endmodule : MulUnitAssertions

`default_nettype wire

// File: dv/MulUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module MulUnitTb;
    import BasicTypes::*;
    import MicroOpTypes::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int DIRECTED_OPS  = 25;
    localparam int RANDOM_CYCLES = 300;
    // stalls offered right after reset plus at most one per random cycle
    localparam int STALL_CYCLES  = 4 + RANDOM_CYCLES;
    localparam int TOTAL_OPS     = DIRECTED_OPS + RANDOM_CYCLES;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_OPS * 3 + STALL_CYCLES + 20;

    logic       clk;
    logic       rst;
    logic       stall;
    logic       opValid;
    DataPath    opA;
    DataPath    opB;
    IntMUL_Code mulCode;
    logic       resultValid;
    DataPath    result;

    int seed;
    int mismatchCount = 0;
    int unexpectedCount = 0;
    int timeoutCount = 0;

    // expected results in issue order
    DataPath expQ[$];
    DataPath expHead = '0;
    int      expCount = 0;

    MulClockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clkGen (
        .clk (clk),
        .rst (rst)
    );

    PipelinedMultiplierUnit DUT (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .opValid     (opValid),
        .opA         (opA),
        .opB         (opB),
        .mulCode     (mulCode),
        .resultValid (resultValid),
        .result      (result)
    );

    bind PipelinedMultiplierUnit MulUnitAssertions protoChk (
        .clk (clk), .rst (rst), .stall (stall), .opValid (opValid),
        .resultValid (resultValid), .result (result)
    );

    // reference model, full 64-bit product of the extended operands
    function automatic DataPath predictResult(IntMUL_Code code, DataPath a, DataPath b);
        logic [2*DATA_WIDTH-1:0] extA;
        logic [2*DATA_WIDTH-1:0] extB;
        logic [2*DATA_WIDTH-1:0] full;
        extA = {{DATA_WIDTH{a[DATA_WIDTH-1] && code != AC_MULHU}}, a};
        extB = {{DATA_WIDTH{b[DATA_WIDTH-1] && (code == AC_MUL || code == AC_MULH)}}, b};
        // wraps mod 2^64, the true product always fits
        full = extA * extB;
        return (code == AC_MUL) ? full[DATA_WIDTH-1:0] : full[2*DATA_WIDTH-1:DATA_WIDTH];
    endfunction

    function automatic IntMUL_Code randomCode();
        logic [1:0] raw;
        raw = 2'($random(seed));
        return IntMUL_Code'(raw);
    endfunction

    // one op offered on the next edge, accepted on the edge after
    task automatic sendOp(input IntMUL_Code code, input DataPath a, input DataPath b);
        @(posedge clk);
        stall   <= 1'b0;
        opValid <= 1'b1;
        opA     <= a;
        opB     <= b;
        mulCode <= code;
    endtask

    task automatic idleFor(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            stall   <= 1'b0;
            opValid <= 1'b0;
        end
    endtask

    // ops offered while stalled, none of them may be taken
    task automatic offerDuringStall(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            stall   <= 1'b1;
            opValid <= 1'b1;
            opA     <= $random(seed);
            opB     <= $random(seed);
            mulCode <= randomCode();
        end
    endtask

    task automatic finishRun();
        int protoCount;
        protoCount = DUT.protoChk.protocolErrors;
        $display("errors: %0d mismatch, %0d unexpected, %0d protocol, %0d timeout",
            mismatchCount, unexpectedCount, protoCount, timeoutCount);
        if (mismatchCount + unexpectedCount + protoCount + timeoutCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // push on accept, pop on each result seen on a non-stalled edge
    always @(posedge clk) begin
        if (!rst && !stall) begin
            if (resultValid && expQ.size() != 0) begin
                expQ.delete(0);
            end
            if (opValid) begin
                expQ.push_back(predictResult(mulCode, opA, opB));
            end
        end
        expCount = expQ.size();
        expHead  = (expCount != 0) ? expQ[0] : '0;
    end

    checkResult: assert property (@(posedge clk) disable iff (rst)
        (resultValid && !stall && expCount != 0) |-> (result == expHead))
    else begin
        $display("Mismatch at %0t: expected %08h, got %08h",
            $time, $sampled(expHead), $sampled(result));
        mismatchCount++;
    end

    noStrayResult: assert property (@(posedge clk) disable iff (rst)
        (resultValid && !stall) |-> (expCount != 0))
    else begin
        $display("Unexpected result at %0t: resultValid high with no operation in flight",
            $time);
        unexpectedCount++;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        timeoutCount++;
        finishRun();
    end

    initial begin
        seed    = 32'hd01b;
        stall   = 1'b0;
        opValid = 1'b0;
        opA     = '0;
        opB     = '0;
        mulCode = AC_MUL;
        wait (rst === 1'b0);

        // quiet after reset, stalled offers must not show up
        idleFor(3);
        offerDuringStall(4);
        idleFor(MUL_PIPELINE_DEPTH + 3);

        // MUL, random then signed corners
        repeat (8) sendOp(AC_MUL, $random(seed), $random(seed));
        sendOp(AC_MUL, 32'hFFFF_FFFD, 32'h0000_0007);
        sendOp(AC_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        // MULH incl. most negative squared
        sendOp(AC_MULH, 32'h8000_0000, 32'h8000_0000);
        sendOp(AC_MULH, 32'hFFFF_FFFE, 32'h0000_0003);
        repeat (4) sendOp(AC_MULH, $random(seed), $random(seed));
        idleFor(2);
        // MULHSU, negative A against all-ones B
        sendOp(AC_MULHSU, 32'hFFFF_FFFB, 32'hFFFF_FFFF);
        sendOp(AC_MULHSU, 32'h8000_0000, 32'hFFFF_FFFF);
        repeat (2) sendOp(AC_MULHSU, $random(seed) | 32'h8000_0000, 32'hFFFF_FFFF);
        // MULHU, max and zero operands
        sendOp(AC_MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        sendOp(AC_MULHU, 32'h0000_0000, 32'hFFFF_FFFF);
        sendOp(AC_MULHU, 32'h1234_5678, 32'h0000_0000);
        repeat (2) sendOp(AC_MULHU, $random(seed), $random(seed));
        idleFor(2);

        // back-to-back stream with random stall pulses and bubbles
        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            stall   <= (($random(seed) & 3) == 0);
            opValid <= (($random(seed) & 7) != 0);
            opA     <= $random(seed);
            opB     <= $random(seed);
            mulCode <= randomCode();
        end
        idleFor(1);

        // drain, then a few more edges to catch stray results
        while (expCount != 0) begin
            @(posedge clk);
        end
        idleFor(MUL_PIPELINE_DEPTH + 4);
        finishRun();
    end

endmodule : MulUnitTb

`default_nettype wire

// File: files.f
logic/BasicTypes.sv
logic/MicroOpTypes.sv
logic/MulStageIf.sv
logic/MulIssueControl.sv
logic/PipelinedMultiplier.sv
logic/MulResultStage.sv
logic/PipelinedMultiplierUnit.sv
dv/MulClockGen.sv
dv/MulUnitAssertions.sv
dv/MulUnitTb.sv

// File: logic/BasicTypes.sv
`default_nettype none

package BasicTypes;

    // operand and result width
    localparam int DATA_WIDTH = 32;

    // register stages inside the multiplier
    // the result stage adds one more
    localparam int MUL_PIPELINE_DEPTH = 3;

    // operands and results
    typedef logic [DATA_WIDTH-1:0] DataPath;

    // full double-width product
    typedef logic [2*DATA_WIDTH-1:0] ProductPath;

endpackage : BasicTypes

`default_nettype wire

// File: logic/MicroOpTypes.sv
`default_nettype none

package MicroOpTypes;

    // integer multiply codes, same encoding as the issue stage
    typedef enum logic [1:0] {
        AC_MUL    = 2'b00,
        AC_MULH   = 2'b01,
        AC_MULHSU = 2'b10,
        AC_MULHU  = 2'b11
    } IntMUL_Code;

    // per-stage control bits travelling beside the product
    typedef logic [1:0] MulSideband;

    // bit positions inside MulSideband
    localparam int SB_VALID = 1;
    localparam int SB_UPPER = 0;

endpackage : MicroOpTypes

`default_nettype wire

// File: logic/MulIssueControl.sv
`timescale 1ns/1ps
`default_nettype none

module MulIssueControl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     opValid,
    input  MicroOpTypes::IntMUL_Code mulCode,
    MulStageIf.ctrl                  stage
);
    import BasicTypes::*;
    import MicroOpTypes::*;

    // one sideband entry per multiplier register stage
    MulSideband sidePipe [MUL_PIPELINE_DEPTH];

    // decoded from the incoming code
    logic getUpper;
    logic opSignA;
    logic opSignB;

    // code decode
    always_comb begin
        // only MULHU reads A as unsigned
        opSignA = (mulCode != AC_MULHU);
        // B is signed for MUL and MULH only
        opSignB = (mulCode == AC_MUL) || (mulCode == AC_MULH);
        // MUL keeps the low word, the rest want the high word
        getUpper = (mulCode != AC_MUL);
    end

    // sideband shift register, moves in step with the product
    always_ff @(posedge clk) begin
        if (rst) begin
            // only valid bits need clearing
            for (int i = 0; i < MUL_PIPELINE_DEPTH; i++) begin
                sidePipe[i][SB_VALID] <= 1'b0;
            end
        end else if (!stall) begin
            // accept edge, inputs ignored while stalled
            sidePipe[0][SB_VALID] <= opValid;
            sidePipe[0][SB_UPPER] <= getUpper;
            for (int i = 1; i < MUL_PIPELINE_DEPTH; i++) begin
                sidePipe[i] <= sidePipe[i-1];
            end
        end
    end

    // stall goes straight through to the datapath
    assign stage.stall = stall;

    // signedness applies at the accept edge,
    // so the multiplier samples it with the operands
    assign stage.signA = opSignA;
    assign stage.signB = opSignB;

    // last entry lines up with the product output
    assign stage.lastValid = sidePipe[MUL_PIPELINE_DEPTH-1][SB_VALID];
    assign stage.selUpper  = sidePipe[MUL_PIPELINE_DEPTH-1][SB_UPPER];

endmodule : MulIssueControl

`default_nettype wire

// File: logic/MulResultStage.sv
`timescale 1ns/1ps
`default_nettype none

module MulResultStage (
    input  logic                   clk,
    input  logic                   rst,
    input  BasicTypes::ProductPath product,
    MulStageIf.dp                  stage,
    output logic                   resultValid,
    output BasicTypes::DataPath    result
);
    import BasicTypes::*;

    // chosen half of the product
    DataPath halfSel;

    // upper word for MULH*, lower word for MUL
    always_comb begin
        if (stage.selUpper) begin
            halfSel = product[2*DATA_WIDTH-1:DATA_WIDTH];
        end else begin
            halfSel = product[DATA_WIDTH-1:0];
        end
    end

    // valid bit of the output register
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else if (!stage.stall) begin
            resultValid <= stage.lastValid;
        end
    end

    // result data, held during stall
    always_ff @(posedge clk) begin
        if (!stage.stall) begin
            result <= halfSel;
        end
    end

endmodule : MulResultStage

`default_nettype wire

// File: logic/MulStageIf.sv
`timescale 1ns/1ps
`default_nettype none

// control to datapath bundle of the multiply unit
interface MulStageIf;

    // pipeline freeze, shared by every stage
    logic stall;

    // operand signedness of the op being accepted
    logic signA;
    logic signB;

    // half select and valid of the op leaving the last multiplier stage
    logic selUpper;
    logic lastValid;

    // control side drives everything
    modport ctrl (
        output stall,
        output signA,
        output signB,
        output selUpper,
        output lastValid
    );

    // datapath side only listens
    modport dp (
        input stall,
        input signA,
        input signB,
        input selUpper,
        input lastValid
    );

endinterface : MulStageIf

`default_nettype wire

// File: logic/PipelinedMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module PipelinedMultiplier #(
    parameter int BIT_WIDTH      = BasicTypes::DATA_WIDTH,
    parameter int PIPELINE_DEPTH = BasicTypes::MUL_PIPELINE_DEPTH
) (
    input  logic                   clk,
    input  BasicTypes::DataPath    srcA,
    input  BasicTypes::DataPath    srcB,
    MulStageIf.dp                  stage,
    output BasicTypes::ProductPath dst
);

    // operand registers, one extra bit for the sign
    logic signed [BIT_WIDTH:0] opAReg;
    logic signed [BIT_WIDTH:0] opBReg;

    // low double-width bits of the signed product
    logic [2*BIT_WIDTH-1:0] product;

    // first stage, sign-extend by the decoded signedness
    // unsigned operands get a zero top bit
    always_ff @(posedge clk) begin
        if (!stage.stall) begin
            opAReg <= {stage.signA & srcA[BIT_WIDTH-1], srcA[BIT_WIDTH-1:0]};
            opBReg <= {stage.signB & srcB[BIT_WIDTH-1], srcB[BIT_WIDTH-1:0]};
        end
    end

    // 33x33 signed multiply
    // evaluated at the product width, which keeps the low bits exact
    assign product = opAReg * opBReg;

    generate
        if (PIPELINE_DEPTH == 1) begin : gSingle
            // single stage, product straight off the operand registers
            assign dst = product;
        end else begin : gMulti
            // remaining stages carry the product
            logic [2*BIT_WIDTH-1:0] prodPipe [PIPELINE_DEPTH-1];

            always_ff @(posedge clk) begin
                if (!stage.stall) begin
                    prodPipe[0] <= product;
                    for (int i = 1; i < PIPELINE_DEPTH-1; i++) begin
                        prodPipe[i] <= prodPipe[i-1];
                    end
                end
            end

            // output of the last stage
            assign dst = prodPipe[PIPELINE_DEPTH-2];
        end
    endgenerate

endmodule : PipelinedMultiplier

`default_nettype wire

// File: logic/PipelinedMultiplierUnit.sv
`timescale 1ns/1ps
`default_nettype none

module PipelinedMultiplierUnit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     opValid,
    input  BasicTypes::DataPath      opA,
    input  BasicTypes::DataPath      opB,
    input  MicroOpTypes::IntMUL_Code mulCode,
    output logic                     resultValid,
    output BasicTypes::DataPath      result
);
    import BasicTypes::*;

    // control to datapath bundle
    MulStageIf stageIf ();

    // full product from the last multiplier stage
    ProductPath product;

    // decode and sideband tracking
    MulIssueControl ctrl (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .opValid (opValid),
        .mulCode (mulCode),
        .stage   (stageIf.ctrl)
    );

    // operands go straight in from the top ports
    PipelinedMultiplier #(
        .BIT_WIDTH      (DATA_WIDTH),
        .PIPELINE_DEPTH (MUL_PIPELINE_DEPTH)
    ) mul (
        .clk   (clk),
        .srcA  (opA),
        .srcB  (opB),
        .stage (stageIf.dp),
        .dst   (product)
    );

    // half select plus output register
    MulResultStage resStage (
        .clk         (clk),
        .rst         (rst),
        .product     (product),
        .stage       (stageIf.dp),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule : PipelinedMultiplierUnit

`default_nettype wire
